// ==== hdl/ntlm_pkg.sv ====
package ntlm_pkg;

  localparam int MAX_CHARS       = 16;
  localparam int MSG_WORDS       = 9;
  localparam int LEN_WORD_IDX    = 14;
  localparam int BLOCK_WORDS     = 16;
  localparam int NUM_STAGES      = 12;
  localparam int STEPS_PER_STAGE = 4;
  localparam int STEPS_PER_ROUND = 16;

  typedef logic [31:0]          word_t;
  typedef logic [7:0]           char_t;
  typedef logic [3:0]           pwd_len_t;
  typedef logic [8*MAX_CHARS-1:0] pwd_str_t;  // char 0 in top byte
  typedef logic [127:0]         digest_t;     // digest byte 0 in top byte

  localparam word_t IV_A = 32'h67452301;
  localparam word_t IV_B = 32'hefcdab89;
  localparam word_t IV_C = 32'h98badcfe;
  localparam word_t IV_D = 32'h10325476;

  localparam word_t ROUND2_K = 32'h5a827999;  // sqrt(2)
  localparam word_t ROUND3_K = 32'h6ed9eba1;  // sqrt(3)

  // message word added by each of the 48 steps
  localparam int unsigned STEP_WORD_IDX [NUM_STAGES*STEPS_PER_STAGE] = '{
    0, 1, 2, 3,
    4, 5, 6, 7,
    8, 9, 10, 11,
    12, 13, 14, 15,
    0, 4, 8, 12,
    1, 5, 9, 13,
    2, 6, 10, 14,
    3, 7, 11, 15,
    0, 8, 4, 12,
    2, 10, 6, 14,
    1, 9, 5, 13,
    3, 11, 7, 15
  };

  // left rotate per step
  localparam int unsigned STEP_SHIFT [NUM_STAGES*STEPS_PER_STAGE] = '{
    3, 7, 11, 19,
    3, 7, 11, 19,
    3, 7, 11, 19,
    3, 7, 11, 19,
    3, 5, 9, 13,
    3, 5, 9, 13,
    3, 5, 9, 13,
    3, 5, 9, 13,
    3, 9, 11, 15,
    3, 9, 11, 15,
    3, 9, 11, 15,
    3, 9, 11, 15
  };

  typedef struct packed {
    word_t a;
    word_t b;
    word_t c;
    word_t d;
  } md4_state_t;

  typedef struct packed {
    word_t [MSG_WORDS-1:0] w;    // low message words, rest are zero
    pwd_len_t              len;  // word 14 is rebuilt from this
  } msg_blk_t;

endpackage

// ==== hdl/ntlm_msg_encode.sv ====
`timescale 1ns/10ps
module ntlm_msg_encode (
  input  logic               clk,
  input  logic               n_rst,
  input  ntlm_pkg::pwd_str_t instr,
  input  ntlm_pkg::pwd_len_t length,
  output ntlm_pkg::msg_blk_t msg
);
  import ntlm_pkg::*;

  pwd_str_t                   str_q;
  pwd_len_t                   len_q;
  logic [8*(MAX_CHARS+2)-1:0] str_ext;

  always_ff @(posedge clk, negedge n_rst) begin
    if (!n_rst) begin
      str_q <= '0;
      len_q <= '0;
    end else begin
      str_q <= instr;
      len_q <= length;
    end
  end

  // two spare zero slots so word 8 can index past the last char
  assign str_ext = {str_q, 16'h0000};

  // UTF-16LE expansion: char 2j in bits 7:0, char 2j+1 in bits 23:16
  always_comb begin
    int unsigned ci;
    int unsigned len_i;
    char_t       ch;
    msg   = '0;
    len_i = 32'(len_q);
    for (int j = 0; j < MSG_WORDS; j++) begin
      for (int h = 0; h < 2; h++) begin
        ci = 2 * j + h;
        ch = str_ext[8*(MAX_CHARS+1-ci) +: 8];
        if (ci < len_i) begin
          msg.w[j][16*h +: 8] = ch;
        end else if (ci == len_i) begin
          msg.w[j][16*h +: 8] = 8'h80;  // md4 pad byte
        end
      end
    end
    msg.len = len_q;
  end

endmodule

// ==== hdl/md4_step_stage.sv ====
`timescale 1ns/10ps
module md4_step_stage #(
  parameter int STAGE_IDX = 0
) (
  input  logic                 clk,
  input  logic                 n_rst,
  input  ntlm_pkg::md4_state_t state_in,
  input  ntlm_pkg::msg_blk_t   msg_in,
  output ntlm_pkg::md4_state_t state_out,
  output ntlm_pkg::msg_blk_t   msg_out
);
  import ntlm_pkg::*;

  word_t      words [BLOCK_WORDS];
  md4_state_t state_nxt;

  function automatic word_t round_fn(int unsigned rnd, word_t x, word_t y, word_t z);
    word_t r;
    case (rnd)
      0:       r = (x & y) | (~x & z);          // F, select
      1:       r = (x & y) | (x & z) | (y & z); // G, majority
      default: r = x ^ y ^ z;                   // H
    endcase
    return r;
  endfunction

  function automatic word_t round_k(int unsigned rnd);
    word_t k;
    case (rnd)
      0:       k = '0;
      1:       k = ROUND2_K;
      default: k = ROUND3_K;
    endcase
    return k;
  endfunction

  function automatic word_t rotl(word_t x, int unsigned n);
    return (x << n) | (x >> ($bits(word_t) - n));
  endfunction

  // full 16-word block, upper words are zero apart from the length
  always_comb begin
    words = '{default: '0};
    for (int j = 0; j < MSG_WORDS; j++) begin
      words[j] = msg_in.w[j];
    end
    words[LEN_WORD_IDX] = word_t'(msg_in.len) << 4;  // chars * 16 bits
  end

  always_comb begin
    word_t       va;
    word_t       vb;
    word_t       vc;
    word_t       vd;
    word_t       t;
    int unsigned s;
    int unsigned rnd;
    va = state_in.a;
    vb = state_in.b;
    vc = state_in.c;
    vd = state_in.d;
    for (int i = 0; i < STEPS_PER_STAGE; i++) begin
      s   = STAGE_IDX * STEPS_PER_STAGE + i;
      rnd = s / STEPS_PER_ROUND;
      t   = va + round_fn(rnd, vb, vc, vd) + words[STEP_WORD_IDX[s]] + round_k(rnd);
      t   = rotl(t, STEP_SHIFT[s]);
      // rename so the next step always updates va, giving a d c b order
      va  = vd;
      vd  = vc;
      vc  = vb;
      vb  = t;
    end
    state_nxt = '{a: va, b: vb, c: vc, d: vd};
  end

  always_ff @(posedge clk, negedge n_rst) begin
    if (!n_rst) begin
      state_out <= '0;
      msg_out   <= '0;
    end else begin
      state_out <= state_nxt;
      msg_out   <= msg_in;
    end
  end

endmodule

// ==== hdl/md4_core.sv ====
`timescale 1ns/10ps
module md4_core (
  input  logic               clk,
  input  logic               n_rst,
  input  ntlm_pkg::msg_blk_t msg,
  output ntlm_pkg::digest_t  hash
);
  import ntlm_pkg::*;

  md4_state_t stage_state [NUM_STAGES+1];
  msg_blk_t   stage_msg   [NUM_STAGES+1];
  md4_state_t fin;

  function automatic word_t bswap(word_t w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

  assign stage_state[0] = '{a: IV_A, b: IV_B, c: IV_C, d: IV_D};
  assign stage_msg[0]   = msg;

  generate
    for (genvar n = 0; n < NUM_STAGES; n++) begin : g_stage
      md4_step_stage #(
        .STAGE_IDX(n)
      ) u_stage (
        .clk      (clk),
        .n_rst    (n_rst),
        .state_in (stage_state[n]),
        .msg_in   (stage_msg[n]),
        .state_out(stage_state[n+1]),
        .msg_out  (stage_msg[n+1])
      );
    end
  endgenerate

  assign fin = stage_state[NUM_STAGES];

  // feed-forward add, then little-endian byte order
  assign hash = {bswap(fin.a + IV_A),
                 bswap(fin.b + IV_B),
                 bswap(fin.c + IV_C),
                 bswap(fin.d + IV_D)};

endmodule

// ==== hdl/ntlm_string_delay.sv ====
`timescale 1ns/10ps
module ntlm_string_delay (
  input  logic               clk,
  input  logic               n_rst,
  input  ntlm_pkg::pwd_str_t instr,
  output ntlm_pkg::pwd_str_t outstr
);
  import ntlm_pkg::*;

  pwd_str_t in_q;                // matches the encoder input register
  pwd_str_t pipe [NUM_STAGES];   // one slot per md4 stage

  always_ff @(posedge clk, negedge n_rst) begin
    if (!n_rst) begin
      in_q <= '0;
      for (int i = 0; i < NUM_STAGES; i++) begin
        pipe[i] <= '0;
      end
    end else begin
      in_q    <= instr;
      pipe[0] <= in_q;
      for (int i = 1; i < NUM_STAGES; i++) begin
        pipe[i] <= pipe[i-1];
      end
    end
  end

  assign outstr = pipe[NUM_STAGES-1];

endmodule

// ==== hdl/ntlm_hash_top.sv ====
`timescale 1ns/10ps
module ntlm_hash_top (
  input  logic               clk,
  input  logic               n_rst,
  input  ntlm_pkg::pwd_str_t instr,
  input  ntlm_pkg::pwd_len_t length,
  output ntlm_pkg::digest_t  hash,
  output ntlm_pkg::pwd_str_t outstr
);
  import ntlm_pkg::*;

  msg_blk_t msg;  // padded block, one cycle after sampling

  ntlm_msg_encode u_encode (
    .clk   (clk),
    .n_rst (n_rst),
    .instr (instr),
    .length(length),
    .msg   (msg)
  );

  md4_core u_core (
    .clk  (clk),
    .n_rst(n_rst),
    .msg  (msg),
    .hash (hash)
  );

  ntlm_string_delay u_str_delay (
    .clk   (clk),
    .n_rst (n_rst),
    .instr (instr),
    .outstr(outstr)
  );

endmodule

// ==== tb/ntlm_hash_tb.sv ====
`timescale 1ns/10ps
module ntlm_hash_tb;
  import ntlm_pkg::*;

  localparam int      CLK_PERIOD = 100;
  localparam int      NAME_CHARS = 32;
  localparam string   STIM_FILE  = "tb/ntlm_stim.txt";
  localparam digest_t CLEAR_HASH = 128'h0123456789abcdeffedcba9876543210;  // iv, little-endian

  typedef logic [8*NAME_CHARS-1:0] name_t;

  typedef struct packed {
    name_t    name;
    logic     is_reset;  // marker line, pulses n_rst
    pwd_len_t len;
    pwd_str_t str;
    digest_t  hash;
  } vec_t;

  typedef struct packed {
    name_t    name;
    pwd_str_t str;
    digest_t  hash;
    int       due;  // edge index after which outputs are checked
  } exp_t;

  logic     clk    = 1'b0;
  logic     n_rst  = 1'b0;
  pwd_str_t instr  = '0;
  pwd_len_t length = '0;
  digest_t  hash;
  pwd_str_t outstr;

  vec_t vecs  [$];
  exp_t exp_q [$];
  int   edge_idx  = 0;
  int   pass_cnt  = 0;
  int   fail_cnt  = 0;
  int   n_items   = 0;
  int   n_resets  = 0;
  logic load_done = 1'b0;

  ntlm_hash_top DUT (
    .clk   (clk),
    .n_rst (n_rst),
    .instr (instr),
    .length(length),
    .hash  (hash),
    .outstr(outstr)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic string name_text(name_t v);
    string      s;
    logic [7:0] ch;
    s = "";
    for (int i = NAME_CHARS - 1; i >= 0; i--) begin
      ch = v[8*i +: 8];
      if (ch != 8'h00) begin
        s = $sformatf("%s%c", s, ch);
      end
    end
    return s;
  endfunction

  task automatic load_vectors();
    int               fd;
    int               len_val;
    name_t            tok;
    pwd_str_t         str_val;
    digest_t          hash_val;
    logic [8*256-1:0] skip_line;
    vec_t             v;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      $display("cannot open stimulus file %s", STIM_FILE);
      fail_cnt++;
    end else begin
      while ($fscanf(fd, "%s", tok) == 1) begin
        v      = '0;
        v.name = tok;
        if (tok == name_t'("#")) begin
          void'($fgets(skip_line, fd));  // rest of a comment line
        end else if (tok == name_t'("reset")) begin
          v.is_reset = 1'b1;
          vecs.push_back(v);
          n_resets++;
        end else if ($fscanf(fd, "%d %h %h", len_val, str_val, hash_val) == 3 &&
                     len_val >= 0 && len_val < MAX_CHARS) begin
          v.len  = pwd_len_t'(len_val);
          v.str  = str_val;
          v.hash = hash_val;
          vecs.push_back(v);
          n_items++;
        end else begin
          $display("stimulus record %s is incomplete or has a bad length", name_text(tok));
          fail_cnt++;
        end
      end
      $fclose(fd);
    end
    if (n_items == 0) begin
      $display("no test vectors were read from %s", STIM_FILE);
      fail_cnt++;
    end
  endtask

  task automatic next_edge();
    @(posedge clk);
    edge_idx++;
  endtask

  task automatic check_hash(input string name, input digest_t exp_val,
                            input digest_t act_val, output bit ok);
    ok = (act_val === exp_val);
    if (!ok) begin
      $display("MISMATCH %s hash: expected %032h, actual %032h", name, exp_val, act_val);
    end
  endtask

  task automatic check_str(input string name, input pwd_str_t exp_val,
                           input pwd_str_t act_val, output bit ok);
    ok = (act_val === exp_val);
    if (!ok) begin
      $display("MISMATCH %s outstr: expected %032h, actual %032h", name, exp_val, act_val);
    end
  endtask

  task automatic finish_test(input string name, input bit ok);
    if (ok) begin
      pass_cnt++;
      $display("test %s: pass", name);
    end else begin
      fail_cnt++;
      $display("test %s: fail", name);
    end
  endtask

  task automatic check_due();
    exp_t  e;
    string nm;
    bit    ok_h;
    bit    ok_s;
    while (exp_q.size() > 0 && exp_q[0].due == edge_idx) begin
      e  = exp_q.pop_front();
      nm = name_text(e.name);
      check_hash(nm, e.hash, hash, ok_h);
      check_str(nm, e.str, outstr, ok_s);
      finish_test(nm, ok_h && ok_s);
    end
  endtask

  task automatic run_cycle(input bit active, input vec_t v);
    exp_t e;
    next_edge();
    if (active) begin
      instr  <= v.str;
      length <= v.len;
      e.name = v.name;
      e.str  = v.str;
      e.hash = v.hash;
      e.due  = edge_idx + 1 + NUM_STAGES;  // sampled on the next edge
      exp_q.push_back(e);
    end else begin
      instr  <= '0;
      length <= '0;
    end
    @(negedge clk);
    check_due();
  endtask

  task automatic reset_mid_stream();
    bit ok_h;
    bit ok_s;
    next_edge();
    n_rst  <= 1'b0;
    instr  <= '0;
    length <= '0;
    $display("reset: %0d items in flight dropped", exp_q.size());
    exp_q.delete();
    repeat (2) next_edge();
    @(negedge clk);
    check_str("after_reset", '0, outstr, ok_s);
    check_hash("after_reset", CLEAR_HASH, hash, ok_h);
    finish_test("after_reset", ok_s && ok_h);
    next_edge();
    n_rst <= 1'b1;
  endtask

  initial begin
    load_vectors();
    load_done = 1'b1;
    repeat (3) next_edge();
    n_rst <= 1'b1;
    foreach (vecs[i]) begin
      if (vecs[i].is_reset) begin
        reset_mid_stream();
      end else begin
        run_cycle(1'b1, vecs[i]);
      end
    end
    while (exp_q.size() > 0) begin
      run_cycle(1'b0, '0);  // drain the pipeline
    end
    $display("tests: %0d passed, %0d failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && pass_cnt > 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // watchdog
  initial begin
    int limit;
    wait (load_done);
    limit = n_items + 4 * n_resets + 3 + NUM_STAGES + 20;
    #(limit * CLK_PERIOD);
    $display("timeout: simulation still running after %0d clock cycles", limit);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

// ==== tb/ntlm_stim.txt ====
# name length string(hex, char 0 in top byte) hash(hex, digest byte 0 first)
# a line holding only the word reset pulses n_rst for 3 cycles
# known digests with clean strings, streamed back to back
empty 0 00000000000000000000000000000000 31d6cfe0d16ae931b73c59d7e0c089c0
len1_a 1 61000000000000000000000000000000 186cb09181e2c2ecaac768c47c729904
len3_123 3 31323300000000000000000000000000 3dbde697d71690a769204beb12283678
len4_test 4 74657374000000000000000000000000 0cb6948805f797bf2a82807973b89537
len4_1234 4 31323334000000000000000000000000 7ce21f17c0aee7fb9ceba532d0546ad6
len5_admin 5 61646d696e0000000000000000000000 209c6174da490caeb422f3fa5a7ae634
len5_12345 5 31323334350000000000000000000000 7a21990fcd3d759941e45c490f143d5f
len6_123456 6 31323334353600000000000000000000 32ed87bdb5fdc5e9cba88547376818d4
len6_qwerty 6 71776572747900000000000000000000 2d20d252a479f485cdf5e171d93985bf
len7_hashcat 7 68617368636174000000000000000000 b4b9b02e6f09a9bd760f388b67351e2b
len8_password 8 70617373776f72640000000000000000 8846f7eaee8fb117ad06bdd830b7586c
len8_Password 8 50617373776f72640000000000000000 a4f49c406510bdcab6824ee7c30fd852
len8_12345678 8 31323334353637380000000000000000 259745cb123a52aa2e693aaacca2db52
len8_p_at_ssw0rd 8 50407373773072640000000000000000 e19ccf75ee54e06b06a5907af13cef42
len9_Password1 9 50617373776f72643100000000000000 64f12cddaa88057e06a81b54e73b949b
len11_Password123 11 50617373776f72643132330000000000 58a478135a93ac3bf058a5ea0e8fdb71
# same passwords with garbage in the bytes past the length
empty_junk 0 deadbeefcafef00d0123456789abcdef 31d6cfe0d16ae931b73c59d7e0c089c0
a_junk 1 61ffffffffffffffffffffffffffffff 186cb09181e2c2ecaac768c47c729904
123_junk 3 31323341424344454647484a4b4c4d4e 3dbde697d71690a769204beb12283678
test_junk 4 74657374746573747465737474657374 0cb6948805f797bf2a82807973b89537
admin_junk 5 61646d696e5a5a5a5a5a5a5a5a5a5a5a 209c6174da490caeb422f3fa5a7ae634
hashcat_junk 7 68617368636174787878787878787878 b4b9b02e6f09a9bd760f388b67351e2b
password_junk 8 70617373776f72640102030405060708 8846f7eaee8fb117ad06bdd830b7586c
password_pad 8 70617373776f72648080808080808080 8846f7eaee8fb117ad06bdd830b7586c
Password1_junk 9 50617373776f726431fedcba98765432 64f12cddaa88057e06a81b54e73b949b
Password123_junk 11 50617373776f72643132332121212121 58a478135a93ac3bf058a5ea0e8fdb71
# thirteen items still in flight when the reset hits, never checked
fl_00 5 61646d696e1111111111111111111111 209c6174da490caeb422f3fa5a7ae634
fl_01 8 70617373776f72642222222222222222 8846f7eaee8fb117ad06bdd830b7586c
fl_02 4 74657374333333333333333333333333 0cb6948805f797bf2a82807973b89537
fl_03 7 68617368636174444444444444444444 b4b9b02e6f09a9bd760f388b67351e2b
fl_04 6 31323334353655555555555555555555 32ed87bdb5fdc5e9cba88547376818d4
fl_05 9 50617373776f72643166666666666666 64f12cddaa88057e06a81b54e73b949b
fl_06 1 61777777777777777777777777777777 186cb09181e2c2ecaac768c47c729904
fl_07 3 31323388888888888888888888888888 3dbde697d71690a769204beb12283678
fl_08 0 99999999999999999999999999999999 31d6cfe0d16ae931b73c59d7e0c089c0
fl_09 6 717765727479aaaaaaaaaaaaaaaaaaaa 2d20d252a479f485cdf5e171d93985bf
fl_10 8 3132333435363738bbbbbbbbbbbbbbbb 259745cb123a52aa2e693aaacca2db52
fl_11 5 3132333435cccccccccccccccccccccc 7a21990fcd3d759941e45c490f143d5f
fl_12 11 50617373776f7264313233dddddddddd 58a478135a93ac3bf058a5ea0e8fdb71
reset
# after the second reset, same latency expected
empty_r 0 00000000000000000000000000000000 31d6cfe0d16ae931b73c59d7e0c089c0
password_r 8 70617373776f72640000000000000000 8846f7eaee8fb117ad06bdd830b7586c
admin_junk_r 5 61646d696e5a5a5a5a5a5a5a5a5a5a5a 209c6174da490caeb422f3fa5a7ae634
Password1_r 9 50617373776f72643100000000000000 64f12cddaa88057e06a81b54e73b949b
hashcat_r 7 68617368636174000000000000000000 b4b9b02e6f09a9bd760f388b67351e2b
qwerty_r 6 71776572747900000000000000000000 2d20d252a479f485cdf5e171d93985bf
12345678_r 8 31323334353637380000000000000000 259745cb123a52aa2e693aaacca2db52
a_junk_r 1 61ffffffffffffffffffffffffffffff 186cb09181e2c2ecaac768c47c729904
Password123_r 11 50617373776f72643132330000000000 58a478135a93ac3bf058a5ea0e8fdb71
p_at_ssw0rd_r 8 50407373773072640000000000000000 e19ccf75ee54e06b06a5907af13cef42

// ==== list.f ====
hdl/ntlm_pkg.sv
hdl/ntlm_msg_encode.sv
hdl/md4_step_stage.sv
hdl/md4_core.sv
hdl/ntlm_string_delay.sv
hdl/ntlm_hash_top.sv
tb/ntlm_hash_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the ntlm hash testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=obj_dir/ntlm_hash_sim

verilator --binary --top-module ntlm_hash_tb -Mdir obj_dir -o ntlm_hash_sim -f list.f
if [ $? -ne 0 ]; then
  echo "error: verilator build failed"
  exit 1
fi

"$BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "error: simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "STATUS: PASS" "$LOG"; then
  exit 0
fi
echo "error: pass message not found in $LOG"
exit 1
